// File: common/stream_pkg.sv
package stream_pkg;

	// ============================================================
	// Beat geometry
	// ============================================================

	localparam int BEAT_BYTES = 8;
	localparam int BEAT_BITS = BEAT_BYTES * 8;

	typedef logic [BEAT_BITS-1:0] beat_data_t;
	typedef logic [BEAT_BYTES-1:0] beat_keep_t;  // One flag per byte lane

	// ============================================================
	// Stream beat
	// ============================================================

	// Keep is contiguous from lane 0, partial only on the last beat
	typedef struct packed {
		beat_data_t data;
		beat_keep_t keep;
		logic last;
	} stream_beat_t;

endpackage

// File: common/header_pkg.sv
package header_pkg;

	// ============================================================
	// Header geometry
	// ============================================================

	localparam int HEADER_BYTES = 6;
	localparam int TAIL_BYTES = stream_pkg::BEAT_BYTES - HEADER_BYTES;  // 2

	typedef logic [HEADER_BYTES*8-1:0] header_word_t;

	// Header in the low lanes, tail bytes above it
	typedef struct packed {
		logic [TAIL_BYTES*8-1:0] tail;
		header_word_t header;
	} first_beat_s;

	// First beat of a packet, seen raw or split into header and tail
	typedef union packed {
		stream_pkg::beat_data_t raw;
		first_beat_s split;
	} first_beat_u;

	// ============================================================
	// Splitter FSM
	// ============================================================

	typedef enum logic [1:0] {
		idle,
		stream,
		extra_beat,  // Leftover bytes go out alone
		drain
	} splitter_state_t;

endpackage

// File: header_splitter/header_splitter.sv
module header_splitter (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     in_valid,
	input  stream_pkg::stream_beat_t in_beat,
	output logic                     in_ready,
	input  logic                     almost_full,
	output logic                     push,
	output stream_pkg::stream_beat_t push_beat,
	output header_pkg::header_word_t header_data,
	output logic                     header_strobe
);

	localparam int HEADER_BITS = header_pkg::HEADER_BYTES * 8;
	localparam int TAIL_BITS = header_pkg::TAIL_BYTES * 8;

	header_pkg::splitter_state_t state;
	header_pkg::splitter_state_t next_state;
	header_pkg::first_beat_u in_view;

	logic accepting;
	logic take;
	logic tail_present;
	logic [TAIL_BITS-1:0] in_tail_data;
	logic [header_pkg::TAIL_BYTES-1:0] in_tail_keep;
	logic [TAIL_BITS-1:0] leftover_data;
	logic [header_pkg::TAIL_BYTES-1:0] leftover_keep;

	assign in_view.raw = in_beat.data;
	assign in_tail_data = in_view.raw[stream_pkg::BEAT_BITS-1 -: TAIL_BITS];
	assign in_tail_keep = in_beat.keep[stream_pkg::BEAT_BYTES-1 -: header_pkg::TAIL_BYTES];
	assign tail_present = |in_tail_keep;  // Last beat spills past one output beat

	// Almost-full leaves room for the push still in the register
	assign in_ready = accepting && !almost_full;
	assign take = in_valid && in_ready;

	// ============================================================
	// FSM
	// ============================================================

	always_comb begin
		next_state = state;
		case (state)
			header_pkg::idle: begin
				if (take) begin
					if (in_beat.last) begin
						next_state = header_pkg::drain;
					end else begin
						next_state = header_pkg::stream;
					end
				end
			end
			header_pkg::stream: begin
				if (take && in_beat.last) begin
					if (tail_present) begin
						next_state = header_pkg::extra_beat;
					end else begin
						next_state = header_pkg::drain;  // Finish one beat early
					end
				end
			end
			header_pkg::extra_beat: begin
				next_state = header_pkg::drain;
			end
			header_pkg::drain: begin
				if (push && push_beat.last) begin
					next_state = header_pkg::idle;
				end
			end
			default: begin
				next_state = header_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= header_pkg::idle;
			accepting <= 1'b0;
			push <= 1'b0;
			header_strobe <= 1'b0;
		end else begin
			state <= next_state;
			accepting <= (next_state == header_pkg::idle) || (next_state == header_pkg::stream);
			header_strobe <= take && (state == header_pkg::idle);
			case (state)
				header_pkg::idle:       push <= take && in_beat.last;
				header_pkg::stream:     push <= take;
				header_pkg::extra_beat: push <= 1'b1;
				default:                push <= 1'b0;
			endcase
		end
	end

	// ============================================================
	// Header capture and realignment
	// ============================================================

	always_ff @(posedge clock) begin
		if (take) begin
			leftover_data <= in_tail_data;
			leftover_keep <= in_tail_keep;
		end

		case (state)
			header_pkg::idle: begin
				if (take) begin
					header_data <= in_view.split.header;
					// Single-beat packet, tail is the whole payload
					push_beat.data <= {{HEADER_BITS{1'b0}}, in_tail_data};
					push_beat.keep <= {{header_pkg::HEADER_BYTES{1'b0}}, in_tail_keep};
					push_beat.last <= 1'b1;
				end
			end
			header_pkg::stream: begin
				if (take) begin
					push_beat.data <= {in_view.raw[HEADER_BITS-1:0], leftover_data};
					push_beat.keep <= {in_beat.keep[header_pkg::HEADER_BYTES-1:0], leftover_keep};
					push_beat.last <= in_beat.last && !tail_present;
				end
			end
			header_pkg::extra_beat: begin
				push_beat.data <= {{HEADER_BITS{1'b0}}, leftover_data};
				push_beat.keep <= {{header_pkg::HEADER_BYTES{1'b0}}, leftover_keep};
				push_beat.last <= 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: source/beat_fifo.sv
module beat_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     push,
	input  stream_pkg::stream_beat_t push_beat,
	input  logic                     pop,
	output logic                     head_valid,
	output stream_pkg::stream_beat_t head_beat,
	output logic                     almost_full
);

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	stream_pkg::stream_beat_t mem [FIFO_DEPTH];

	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	// Wraps at any depth, not only powers of two
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == (PTR_BITS+1)'(FIFO_DEPTH));
	assign do_push = push && !full;
	assign do_pop = pop && head_valid;

	assign head_valid = (count != '0);
	assign head_beat = mem[rd_ptr];  // Show-ahead
	assign almost_full = (count >= (PTR_BITS+1)'(FIFO_DEPTH - 2));

	// ============================================================
	// Pointers and occupancy
	// ============================================================

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_beat;
		end
	end

endmodule

// File: source/egress_stage.sv
module egress_stage (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     head_valid,
	input  stream_pkg::stream_beat_t head_beat,
	output logic                     pop,
	output logic                     out_valid,
	output stream_pkg::stream_beat_t out_beat,
	input  logic                     out_ready
);

	logic slot_free;

	// Register empty or being taken this cycle
	assign slot_free = !out_valid || out_ready;
	assign pop = head_valid && slot_free;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (slot_free) begin
			out_valid <= head_valid;
		end
	end

	// Held while the receiver stalls
	always_ff @(posedge clock) begin
		if (pop) begin
			out_beat <= head_beat;
		end
	end

endmodule

// File: source/header_strip_top.sv
module header_strip_top #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     in_valid,
	input  stream_pkg::stream_beat_t in_beat,
	output logic                     in_ready,
	output logic                     out_valid,
	output stream_pkg::stream_beat_t out_beat,
	input  logic                     out_ready,
	output header_pkg::header_word_t header_data,
	output logic                     header_strobe
);

	logic push;
	logic almost_full;
	logic head_valid;
	logic pop;
	stream_pkg::stream_beat_t push_beat;
	stream_pkg::stream_beat_t head_beat;

	// ============================================================
	// Splitter, buffer, output register
	// ============================================================

	header_splitter header_splitter_i (
		.clock         (clock),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_beat       (in_beat),
		.in_ready      (in_ready),
		.almost_full   (almost_full),
		.push          (push),
		.push_beat     (push_beat),
		.header_data   (header_data),
		.header_strobe (header_strobe)
	);

	beat_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) beat_fifo_i (
		.clock       (clock),
		.reset       (reset),
		.push        (push),
		.push_beat   (push_beat),
		.pop         (pop),
		.head_valid  (head_valid),
		.head_beat   (head_beat),
		.almost_full (almost_full)
	);

	egress_stage egress_stage_i (
		.clock      (clock),
		.reset      (reset),
		.head_valid (head_valid),
		.head_beat  (head_beat),
		.pop        (pop),
		.out_valid  (out_valid),
		.out_beat   (out_beat),
		.out_ready  (out_ready)
	);

endmodule

// File: testbench/header_strip_cases.svh
// length     total packet bytes, header included
// gap_mask   bit set holds in_valid low that cycle (cycle mod 16)
// stall_mask bit set holds out_ready low that cycle (cycle mod 16)
typedef struct packed {
	logic [15:0] length;
	logic [15:0] gap_mask;
	logic [15:0] stall_mask;
} packet_case_t;

localparam int NUM_CASES = 20;
localparam int MAX_BYTES = 256;

// ============================================================
// Packet table, applied in order
// ============================================================

localparam packet_case_t CASES [NUM_CASES] = '{
	// Single first-and-last beat
	'{16'd7, 16'h0000, 16'h0000},
	'{16'd8, 16'h0000, 16'h0000},
	// Final input beat holds 1 to 6 bytes, one beat fewer out
	'{16'd9, 16'h0000, 16'h0000},
	'{16'd14, 16'h0000, 16'h0000},
	'{16'd22, 16'h00aa, 16'h0000},
	'{16'd30, 16'h0000, 16'h5555},
	// Final input beat holds 7 or 8 bytes, extra beat out
	'{16'd15, 16'h0000, 16'h0000},
	'{16'd16, 16'h0000, 16'h0000},
	'{16'd24, 16'h0f0f, 16'h0000},
	'{16'd31, 16'h0000, 16'h3333},
	// Back-to-back short packets
	'{16'd7, 16'h0000, 16'h0f0f},
	'{16'd8, 16'h0000, 16'h0f0f},
	'{16'd13, 16'h0000, 16'h0f0f},
	// Long receiver stalls, FIFO fills up
	'{16'd64, 16'h0000, 16'hfff0},
	'{16'd200, 16'h0000, 16'hfffe},
	'{16'd47, 16'h0000, 16'hff00},
	// Input gaps and stalls together
	'{16'd120, 16'h1248, 16'hfff0},
	'{16'd40, 16'hf0f0, 16'h00ff},
	'{16'd8, 16'h0001, 16'hfffe},
	'{16'd95, 16'h0000, 16'h0000}
};

// File: testbench/header_strip_tb.sv
module header_strip_tb;
	timeunit 1ns;
	timeprecision 1ps;

	`include "header_strip_cases.svh"

	logic clock;
	logic reset;
	logic in_valid;
	stream_pkg::stream_beat_t in_beat;
	logic in_ready;
	logic out_valid;
	stream_pkg::stream_beat_t out_beat;
	logic out_ready;
	header_pkg::header_word_t header_data;
	logic header_strobe;

	logic [7:0] pkt [MAX_BYTES];
	header_pkg::header_word_t exp_headers [$];
	stream_pkg::stream_beat_t exp_beats [$];
	integer seed = 40;
	int active_case = 0;
	int in_cycle = 0;
	int out_cycle = 0;

	header_strip_top #(
		.FIFO_DEPTH (16)
	) header_strip_top_i (
		.clock         (clock),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_beat       (in_beat),
		.in_ready      (in_ready),
		.out_valid     (out_valid),
		.out_beat      (out_beat),
		.out_ready     (out_ready),
		.header_data   (header_data),
		.header_strobe (header_strobe)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = !clock;
	end

	// ============================================================
	// Helpers
	// ============================================================

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic logic [63:0] byte_mask(input stream_pkg::beat_keep_t keep);
		logic [63:0] mask;
		mask = '0;
		for (int i = 0; i < stream_pkg::BEAT_BYTES; i++) begin
			if (keep[i]) mask[i*8 +: 8] = 8'hff;
		end
		return mask;
	endfunction

	// Expected header from bytes 0 to 5 and payload packed 8 per beat
	task automatic record_expected(input int length);
		header_pkg::header_word_t header;
		stream_pkg::stream_beat_t beat;
		int lane;
		header = '0;
		for (int i = 0; i < header_pkg::HEADER_BYTES; i++) header[i*8 +: 8] = pkt[i];
		exp_headers.push_back(header);
		beat = '0;
		lane = 0;
		for (int i = header_pkg::HEADER_BYTES; i < length; i++) begin
			beat.data[lane*8 +: 8] = pkt[i];
			beat.keep[lane] = 1'b1;
			lane++;
			if (lane == stream_pkg::BEAT_BYTES || i == length - 1) begin
				beat.last = (i == length - 1);
				exp_beats.push_back(beat);
				beat = '0;
				lane = 0;
			end
		end
	endtask

	function automatic stream_pkg::stream_beat_t input_beat(input int length, input int index);
		stream_pkg::stream_beat_t beat;
		int pos;
		beat = '0;
		for (int j = 0; j < stream_pkg::BEAT_BYTES; j++) begin
			pos = index * stream_pkg::BEAT_BYTES + j;
			if (pos < length) begin
				beat.data[j*8 +: 8] = pkt[pos];
				beat.keep[j] = 1'b1;
			end
		end
		beat.last = ((index + 1) * stream_pkg::BEAT_BYTES >= length);
		return beat;
	endfunction

	task automatic send_packet(input int row);
		int length;
		int n_beats;
		int index;
		logic sent;
		length = CASES[row].length;
		for (int j = 0; j < length; j++) pkt[j] = 8'($random(seed));
		record_expected(length);
		n_beats = (length + stream_pkg::BEAT_BYTES - 1) / stream_pkg::BEAT_BYTES;
		index = 0;
		while (index < n_beats) begin
			if (!in_valid) in_valid = !CASES[row].gap_mask[in_cycle % 16];  // Gap before offer
			in_beat = input_beat(length, index);
			@(negedge clock);
			sent = in_valid && in_ready;
			@(posedge clock);
			#1;
			in_cycle++;
			if (sent) begin
				index++;
				in_valid = 1'b0;
			end
		end
	endtask

	function automatic int total_bytes();
		int sum;
		sum = 0;
		for (int i = 0; i < NUM_CASES; i++) sum += CASES[i].length;
		return sum;
	endfunction

	// ============================================================
	// Receiver, checker, watchdog
	// ============================================================

	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			out_ready = !CASES[active_case].stall_mask[out_cycle % 16];
			out_cycle++;
		end
	end

	always @(negedge clock) begin
		if (!reset && header_strobe) begin
			assert (exp_headers.size() != 0) else begin
				$display("Header strobe at %0t ns with no packet pending", $time);
				$display("FAIL: see errors above");
				$fatal(1, "Unexpected header");
			end
			check_value("header_data", exp_headers.pop_front(), header_data);
		end
		if (!reset && out_valid && out_ready) begin
			stream_pkg::stream_beat_t exp;
			assert (exp_beats.size() != 0) else begin
				$display("Output beat at %0t ns with no payload expected", $time);
				$display("FAIL: see errors above");
				$fatal(1, "Unexpected beat");
			end
			exp = exp_beats.pop_front();
			check_value("out_beat.last", exp.last, out_beat.last);
			check_value("out_beat.keep", exp.keep, out_beat.keep);
			check_value("out_beat.data", exp.data & byte_mask(exp.keep),
				out_beat.data & byte_mask(exp.keep));
		end
	end

	initial begin
		int limit;
		limit = total_bytes() * 40;
		repeat (limit) @(posedge clock);
		$display("Timeout: run did not finish within %0d cycles", limit);
		$display("FAIL: see errors above");
		$fatal(1, "Watchdog expired");
	end

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_beat = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		check_value("in_ready", 0, in_ready);
		check_value("out_valid", 0, out_valid);
		check_value("header_strobe", 0, header_strobe);
		@(posedge clock);
		#1;
		reset = 1'b0;
		repeat (3) begin  // Quiet until the first packet
			@(negedge clock);
			check_value("out_valid", 0, out_valid);
			check_value("header_strobe", 0, header_strobe);
		end
		@(posedge clock);
		#1;
		for (int row = 0; row < NUM_CASES; row++) begin
			active_case = row;
			send_packet(row);
		end
		while (exp_beats.size() != 0 || exp_headers.size() != 0) @(posedge clock);
		repeat (10) @(posedge clock);  // Catch stray beats
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: project.f
+incdir+testbench
common/stream_pkg.sv
common/header_pkg.sv
header_splitter/header_splitter.sv
source/beat_fifo.sv
source/egress_stage.sv
source/header_strip_top.sv
testbench/header_strip_tb.sv

// File: Bender.yml
package:
  name: header_strip

sources:
  - common/stream_pkg.sv
  - common/header_pkg.sv
  - header_splitter/header_splitter.sv
  - source/beat_fifo.sv
  - source/egress_stage.sv
  - source/header_strip_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/header_strip_tb.sv
